// ==== flist.f ====
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_addsub.sv
rtl/alu_shift.sv
rtl/alu_mask.sv
rtl/alu_other.sv
rtl/alu_ctrl.sv
rtl/alu_unit.sv
tb/tb_clkgen.sv
tb/alu_unit_sva.sv
tb/alu_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = alu_unit_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **
FAIL_MSG  = ** FAIL **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/alu_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_unit_tb;
  import alu_pkg::*;

  localparam int          NUM_UOPS    = 2000;
  localparam int          MAX_CYCLES  = 20000;
  localparam int          RST_TIMEOUT = 20;
  localparam int          SHW         = $clog2(`ELEN);
  localparam logic [31:0] SEED        = 32'hacac_046f;

  logic              clk;
  logic              rst;
  logic              uop_valid;
  alu_op_e           uop_op;
  vreg_t             uop_vs1;
  vreg_t             uop_vs2;
  logic [`LANES-1:0] uop_v0;
  rob_tag_t          uop_tag;
  logic              result_valid;
  rob_tag_t          result_tag;
  vreg_t             result_data;

  // expected ROB output, one cycle behind the drive
  logic     exp_valid;
  rob_tag_t exp_tag;
  vreg_t    exp_data;

  int cycle_cnt;
  int uop_cnt;
  int wait_cnt;

  tb_clkgen u_clkgen (
    .clk (clk)
  );

  alu_unit uut (
    .clk          (clk),
    .rst          (rst),
    .uop_valid    (uop_valid),
    .uop_op       (uop_op),
    .uop_vs1      (uop_vs1),
    .uop_vs2      (uop_vs2),
    .uop_v0       (uop_v0),
    .uop_tag      (uop_tag),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data)
  );

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_fail($sformatf("Mismatch at %0t ns: result_valid got %b, expected %b",
                               $time, got, exp));
    end
  endtask

  task automatic check_tag(input rob_tag_t got, input rob_tag_t exp);
    if (got !== exp) begin
      stop_with_fail($sformatf("Mismatch at %0t ns: result_tag got %h, expected %h",
                               $time, got, exp));
    end
  endtask

  task automatic check_data(input vreg_t got, input vreg_t exp);
    if (got !== exp) begin
      stop_with_fail($sformatf("Mismatch at %0t ns: result_data got %h, expected %h",
                               $time, got, exp));
    end
  endtask

  // enum ends at OP_VMV
  function automatic logic op_legal(input logic [3:0] code);
    return code <= OP_VMV;
  endfunction

  function automatic vreg_t rand_vec();
    logic [`VLEN+31:0] acc;
    int                w;
    acc = '0;
    for (w = 0; w * 32 < `VLEN; w++) begin
      acc[w*32 +: 32] = $urandom;
    end
    return acc[`VLEN-1:0];
  endfunction

  // reference behavior per lane, vs2 is the first operand
  function automatic vreg_t model_result(input alu_op_e op, input vreg_t vs1,
                                         input vreg_t vs2, input logic [`LANES-1:0] v0);
    vreg_t            res;
    logic [`ELEN-1:0] a;
    logic [`ELEN-1:0] b;
    logic [`ELEN-1:0] r;
    logic [SHW-1:0]   sh;
    logic             is_cmp;
    int               i;
    res    = '0;
    is_cmp = op inside {OP_VMSEQ, OP_VMSNE, OP_VMSLT, OP_VMSLTU};
    for (i = 0; i < `LANES; i++) begin
      a  = vs2[i*`ELEN +: `ELEN];
      b  = vs1[i*`ELEN +: `ELEN];
      sh = b[SHW-1:0];
      r  = '0;
      case (op)
        OP_VADD:   r = a + b;
        OP_VSUB:   r = a - b;
        OP_VRSUB:  r = b - a;
        OP_VSLL:   r = a << sh;
        OP_VSRL:   r = a >> sh;
        OP_VSRA:   r = $signed(a) >>> sh;
        OP_VMSEQ:  res[i] = (a == b);
        OP_VMSNE:  res[i] = (a != b);
        OP_VMSLT:  res[i] = ($signed(a) < $signed(b));
        OP_VMSLTU: res[i] = (a < b);
        OP_VMIN:   r = ($signed(a) < $signed(b)) ? a : b;
        OP_VMAX:   r = ($signed(a) < $signed(b)) ? b : a;
        OP_VMERGE: r = v0[i] ? b : a;
        OP_VMV:    r = b;
        default:   r = '0;
      endcase
      // compares only fill the low mask bits
      if (!is_cmp) begin
        res[i*`ELEN +: `ELEN] = r;
      end
    end
    return res;
  endfunction

  task automatic next_cycle();
    @(negedge clk);
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      stop_with_fail("stimulus loop ran past its cycle limit");
    end
  endtask

  task automatic drive_uop();
    logic [31:0] r;
    logic [3:0]  code;
    int          i;
    r         = $urandom;
    uop_valid = (r[1:0] != 2'b00);
    if (r[4:2] == 3'd0) begin
      // codes past OP_VMV
      code = 4'd14 + {3'b000, r[5]};
    end else begin
      code = 4'($urandom_range(13));
    end
    uop_op  = alu_op_e'(code);
    uop_vs1 = rand_vec();
    uop_vs2 = rand_vec();
    uop_v0  = r[8 +: `LANES];
    uop_tag = r[16 +: `ROB_TAG_W];
    // equal lanes now and then, for seq/sne and min/max ties
    if (r[6]) begin
      for (i = 0; i < `LANES; i++) begin
        if (r[24 + i]) begin
          uop_vs1[i*`ELEN +: `ELEN] = uop_vs2[i*`ELEN +: `ELEN];
        end
      end
    end
    exp_valid = uop_valid && op_legal(code);
    if (exp_valid) begin
      exp_tag  = uop_tag;
      exp_data = model_result(uop_op, uop_vs1, uop_vs2, uop_v0);
    end
    if (uop_valid) begin
      uop_cnt++;
    end
  endtask

  task automatic check_result();
    check_valid(result_valid, exp_valid);
    if (exp_valid) begin
      check_tag(result_tag, exp_tag);
      check_data(result_data, exp_data);
    end
  endtask

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  initial begin
    void'($urandom(SEED));
    // a legal uop held through reset must not reach the ROB
    uop_valid = 1'b1;
    uop_op    = OP_VADD;
    uop_vs1   = rand_vec();
    uop_vs2   = rand_vec();
    uop_v0    = '0;
    uop_tag   = '1;
    // the same uop is taken at the first edge after release
    exp_valid = 1'b1;
    exp_tag   = uop_tag;
    exp_data  = model_result(uop_op, uop_vs1, uop_vs2, uop_v0);
    cycle_cnt = 0;
    uop_cnt   = 0;
    wait_cnt  = 0;

    @(posedge clk);
    while (rst !== 1'b0) begin
      // ROB output stays cleared while rst is high
      @(negedge clk);
      check_valid(result_valid, 1'b0);
      check_tag(result_tag, '0);
      check_data(result_data, '0);
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > RST_TIMEOUT) begin
        stop_with_fail("reset was not released in time");
      end
    end
    next_cycle();
    check_result();

    while (uop_cnt < NUM_UOPS) begin
      drive_uop();
      next_cycle();
      check_result();
    end

    // one idle cycle at the end, valid must drop
    uop_valid = 1'b0;
    exp_valid = 1'b0;
    next_cycle();
    check_result();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/alu_unit_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_unit_sva (
  input logic             clk,
  input logic             rst,
  input logic             uop_valid,
  input alu_pkg::alu_op_e uop_op,
  input logic             result_valid,
  input alu_pkg::vreg_t   result_data
);
  import alu_pkg::*;

  // reset clears the submit strobe
  a_rst_clears_valid: assert property (@(posedge clk) rst |=> !result_valid)
    else $error("result_valid high in the cycle after reset");

  // every legal uop comes back one cycle later
  a_legal_uop_submits: assert property (@(posedge clk) disable iff (rst)
    (uop_valid && (uop_op <= OP_VMV)) |=> result_valid)
    else $error("legal uop did not raise result_valid one cycle later");

  a_data_known: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> !$isunknown(result_data))
    else $error("result_data has unknown bits while result_valid is high");

endmodule

bind alu_unit alu_unit_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .uop_valid    (uop_valid),
  .uop_op       (uop_op),
  .result_valid (result_valid),
  .result_data  (result_data)
);

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk
);

  // 8 ns period
  localparam int HALF_PERIOD = 4;

  initial begin
    clk = 1'b0;
  end

  always begin
    #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              uop_valid,
  input  alu_pkg::alu_op_e  uop_op,
  input  alu_pkg::vreg_t    uop_vs1,
  input  alu_pkg::vreg_t    uop_vs2,
  input  logic [`LANES-1:0] uop_v0,
  input  alu_pkg::rob_tag_t uop_tag,
  output logic              result_valid,
  output alu_pkg::rob_tag_t result_tag,
  output alu_pkg::vreg_t    result_data
);
  import alu_pkg::*;

  logic  en_addsub;
  logic  en_shift;
  logic  en_mask;
  logic  en_other;
  vreg_t addsub_data;
  vreg_t shift_data;
  vreg_t mask_data;
  vreg_t other_data;

  // decode, result select and ROB register
  alu_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .uop_valid    (uop_valid),
    .uop_op       (uop_op),
    .uop_tag      (uop_tag),
    .addsub_data  (addsub_data),
    .shift_data   (shift_data),
    .mask_data    (mask_data),
    .other_data   (other_data),
    .en_addsub    (en_addsub),
    .en_shift     (en_shift),
    .en_mask      (en_mask),
    .en_other     (en_other),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data)
  );

  alu_addsub u_addsub (
    .en   (en_addsub),
    .op   (uop_op),
    .vs1  (uop_vs1),
    .vs2  (uop_vs2),
    .data (addsub_data)
  );

  alu_shift u_shift (
    .en   (en_shift),
    .op   (uop_op),
    .vs1  (uop_vs1),
    .vs2  (uop_vs2),
    .data (shift_data)
  );

  alu_mask u_mask (
    .en   (en_mask),
    .op   (uop_op),
    .vs1  (uop_vs1),
    .vs2  (uop_vs2),
    .data (mask_data)
  );

  // only this unit looks at v0
  alu_other u_other (
    .en   (en_other),
    .op   (uop_op),
    .vs1  (uop_vs1),
    .vs2  (uop_vs2),
    .v0   (uop_v0),
    .data (other_data)
  );

endmodule

`default_nettype wire

// ==== rtl/alu_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              uop_valid,
  input  alu_pkg::alu_op_e  uop_op,
  input  alu_pkg::rob_tag_t uop_tag,
  input  alu_pkg::vreg_t    addsub_data,
  input  alu_pkg::vreg_t    shift_data,
  input  alu_pkg::vreg_t    mask_data,
  input  alu_pkg::vreg_t    other_data,
  output logic              en_addsub,
  output logic              en_shift,
  output logic              en_mask,
  output logic              en_other,
  output logic              result_valid,
  output alu_pkg::rob_tag_t result_tag,
  output alu_pkg::vreg_t    result_data
);
  import alu_pkg::*;

  alu_unit_e unit_sel;
  logic      op_legal;
  logic      issue;
  vreg_t     sel_data;

  // opcode to unit decode
  always_comb begin
    unit_sel = UNIT_ADDSUB;
    op_legal = 1'b1;
    case (uop_op)
      OP_VADD, OP_VSUB, OP_VRSUB:                unit_sel = UNIT_ADDSUB;
      OP_VSLL, OP_VSRL, OP_VSRA:                 unit_sel = UNIT_SHIFT;
      OP_VMSEQ, OP_VMSNE, OP_VMSLT, OP_VMSLTU:   unit_sel = UNIT_MASK;
      OP_VMIN, OP_VMAX, OP_VMERGE, OP_VMV:       unit_sel = UNIT_OTHER;
      default:                                   op_legal = 1'b0;
    endcase
  end

  assign issue = uop_valid & op_legal;

  // only one unit toggles per uop
  assign en_addsub = issue && (unit_sel == UNIT_ADDSUB);
  assign en_shift  = issue && (unit_sel == UNIT_SHIFT);
  assign en_mask   = issue && (unit_sel == UNIT_MASK);
  assign en_other  = issue && (unit_sel == UNIT_OTHER);

  always_comb begin
    case (unit_sel)
      UNIT_ADDSUB: sel_data = addsub_data;
      UNIT_SHIFT:  sel_data = shift_data;
      UNIT_MASK:   sel_data = mask_data;
      default:     sel_data = other_data;
    endcase
  end

  // submit to ROB one cycle after issue
  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      result_tag   <= '0;
      result_data  <= '0;
    end else begin
      result_valid <= issue;
      // hold payload on idle cycles
      if (issue) begin
        result_tag  <= uop_tag;
        result_data <= sel_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/alu_other.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_other (
  input  logic              en,
  input  alu_pkg::alu_op_e  op,
  input  alu_pkg::vreg_t    vs1,
  input  alu_pkg::vreg_t    vs2,
  input  logic [`LANES-1:0] v0,
  output alu_pkg::vreg_t    data
);
  import alu_pkg::*;

  vreg_t             opa;
  vreg_t             opb;
  logic [`LANES-1:0] msk;

  assign opa = en ? vs2 : '0;
  assign opb = en ? vs1 : '0;
  assign msk = en ? v0 : '0;

  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    logic [`ELEN-1:0] a;
    logic [`ELEN-1:0] b;
    logic             lt;
    logic [`ELEN-1:0] res;

    assign a = opa[i*`ELEN +: `ELEN];
    assign b = opb[i*`ELEN +: `ELEN];

    // one signed compare serves both min and max
    assign lt = ($signed(a) < $signed(b));

    always_comb begin
      case (op)
        OP_VMIN:   res = lt ? a : b;
        OP_VMAX:   res = lt ? b : a;
        // v0 set picks vs1
        OP_VMERGE: res = msk[i] ? b : a;
        OP_VMV:    res = b;
        default:   res = '0;
      endcase
    end

    assign data[i*`ELEN +: `ELEN] = res;
  end

endmodule

`default_nettype wire

// ==== rtl/alu_mask.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_mask (
  input  logic             en,
  input  alu_pkg::alu_op_e op,
  input  alu_pkg::vreg_t   vs1,
  input  alu_pkg::vreg_t   vs2,
  output alu_pkg::vreg_t   data
);
  import alu_pkg::*;

  vreg_t              opa;
  vreg_t              opb;
  logic [`LANES-1:0]  bits;

  assign opa = en ? vs2 : '0;
  assign opb = en ? vs1 : '0;

  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    logic [`ELEN-1:0] a;
    logic [`ELEN-1:0] b;
    logic [`ELEN:0]   diff;
    logic             eq;
    logic             ltu;
    logic             lts;
    logic             hit;

    assign a = opa[i*`ELEN +: `ELEN];
    assign b = opb[i*`ELEN +: `ELEN];

    // shared subtractor, borrow out gives the unsigned compare
    assign diff = {1'b0, a} - {1'b0, b};
    assign eq   = (diff[`ELEN-1:0] == '0);
    assign ltu  = diff[`ELEN];
    // signs differ: the negative side is smaller
    assign lts  = (a[`ELEN-1] ^ b[`ELEN-1]) ? a[`ELEN-1] : ltu;

    always_comb begin
      case (op)
        OP_VMSEQ:  hit = eq;
        OP_VMSNE:  hit = ~eq;
        OP_VMSLT:  hit = lts;
        OP_VMSLTU: hit = ltu;
        default:   hit = 1'b0;
      endcase
    end

    // zeroed operands still compare equal, so qualify with en
    assign bits[i] = en & hit;
  end

  always_comb begin
    data = '0;
    data[`LANES-1:0] = bits;
  end

endmodule

`default_nettype wire

// ==== rtl/alu_shift.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_shift (
  input  logic             en,
  input  alu_pkg::alu_op_e op,
  input  alu_pkg::vreg_t   vs1,
  input  alu_pkg::vreg_t   vs2,
  output alu_pkg::vreg_t   data
);
  import alu_pkg::*;

  localparam int SHW = $clog2(`ELEN);

  vreg_t opa;
  vreg_t opb;
  logic  is_sll;
  logic  is_sra;

  assign opa = en ? vs2 : '0;
  assign opb = en ? vs1 : '0;

  assign is_sll = (op == OP_VSLL);
  assign is_sra = (op == OP_VSRA);

  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    logic [`ELEN-1:0]   src;
    logic [SHW-1:0]     amt;
    logic               fill;
    logic [2*`ELEN-1:0] ext;
    logic [2*`ELEN-1:0] rsh;

    assign src  = opa[i*`ELEN +: `ELEN];
    // only the low bits of the vs1 lane count
    assign amt  = opb[i*`ELEN +: SHW];
    assign fill = is_sra & src[`ELEN-1];

    // srl and sra share one right shifter, sign fill comes from the upper half
    assign ext = {{`ELEN{fill}}, src};
    assign rsh = ext >> amt;

    assign data[i*`ELEN +: `ELEN] = is_sll ? (src << amt) : rsh[`ELEN-1:0];
  end

endmodule

`default_nettype wire

// ==== rtl/alu_addsub.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_cfg.svh"

module alu_addsub (
  input  logic             en,
  input  alu_pkg::alu_op_e op,
  input  alu_pkg::vreg_t   vs1,
  input  alu_pkg::vreg_t   vs2,
  output alu_pkg::vreg_t   data
);
  import alu_pkg::*;

  vreg_t opa;
  vreg_t opb;
  logic  rev;
  logic  inv;

  // operands stay quiet while the unit is idle
  assign opa = en ? vs2 : '0;
  assign opb = en ? vs1 : '0;

  // vrsub swaps operands, both subtracts invert the subtrahend
  assign rev = en && (op == OP_VRSUB);
  assign inv = en && (op != OP_VADD);

  for (genvar i = 0; i < `LANES; i++) begin : g_lane
    logic [`ELEN-1:0] lhs;
    logic [`ELEN-1:0] rhs;
    logic [`ELEN-1:0] cin;

    assign lhs = rev ? opb[i*`ELEN +: `ELEN] : opa[i*`ELEN +: `ELEN];
    assign rhs = rev ? opa[i*`ELEN +: `ELEN] : opb[i*`ELEN +: `ELEN];
    assign cin = {{(`ELEN-1){1'b0}}, inv};

    // one adder per lane, carry out dropped so lanes wrap
    assign data[i*`ELEN +: `ELEN] = lhs + (rhs ^ {`ELEN{inv}}) + cin;
  end

endmodule

`default_nettype wire

// ==== rtl/alu_pkg.sv ====
`default_nettype none

`include "alu_cfg.svh"

package alu_pkg;

  // whole vector register
  typedef logic [`VLEN-1:0] vreg_t;

  // reorder buffer entry index
  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

  // alu micro-op opcodes, codes 14 and 15 are illegal
  typedef enum logic [3:0] {
    OP_VADD   = 4'd0,
    OP_VSUB   = 4'd1,
    OP_VRSUB  = 4'd2,
    OP_VSLL   = 4'd3,
    OP_VSRL   = 4'd4,
    OP_VSRA   = 4'd5,
    OP_VMSEQ  = 4'd6,
    OP_VMSNE  = 4'd7,
    OP_VMSLT  = 4'd8,
    OP_VMSLTU = 4'd9,
    OP_VMIN   = 4'd10,
    OP_VMAX   = 4'd11,
    OP_VMERGE = 4'd12,
    OP_VMV    = 4'd13
  } alu_op_e;

  // datapath unit that executes the uop
  typedef enum logic [1:0] {
    UNIT_ADDSUB = 2'd0,
    UNIT_SHIFT  = 2'd1,
    UNIT_MASK   = 2'd2,
    UNIT_OTHER  = 2'd3
  } alu_unit_e;

endpackage

`default_nettype wire

// ==== rtl/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// vector register width in bits
`define VLEN 32

// element width of one lane
`define ELEN 8

// lanes per vector register
`define LANES (`VLEN / `ELEN)

// ROB entry index width
`define ROB_TAG_W 4

`endif
